//--- hw/mips_macros.svh
// shared constants for the MIPS core, included by the control unit, ALU, bus interface and testbench
`ifndef MIPS_MACROS_SVH
`define MIPS_MACROS_SVH

`define RESET_VECTOR 32'hBFC00000 // first fetch address after reset
`define HALT_ADDR    32'h00000000 // jumping here stops the core

// primary opcodes
`define OP_SPECIAL 6'b000000 // R-type, funct selects the operation
`define OP_J       6'b000010
`define OP_JAL     6'b000011
`define OP_BEQ     6'b000100
`define OP_BNE     6'b000101
`define OP_ADDIU   6'b001001
`define OP_ANDI    6'b001100
`define OP_ORI     6'b001101
`define OP_XORI    6'b001110
`define OP_LUI     6'b001111
`define OP_LW      6'b100011
`define OP_SW      6'b101011

// funct codes for OP_SPECIAL
`define FN_JR   6'b001000
`define FN_JALR 6'b001001
`define FN_ADDU 6'b100001
`define FN_SUBU 6'b100011
`define FN_AND  6'b100100
`define FN_OR   6'b100101
`define FN_XOR  6'b100110
`define FN_SLT  6'b101010
`define FN_SLTU 6'b101011

// alu operation codes
`define ALU_ADD  4'd0
`define ALU_SUB  4'd1
`define ALU_SLT  4'd2
`define ALU_SLTU 4'd3
`define ALU_AND  4'd4
`define ALU_OR   4'd5
`define ALU_XOR  4'd6
`define ALU_LUI  4'd7 // b shifted up by 16
`define ALU_EQ   4'd8 // zero flag set when a equals b

`endif

//--- hw/mipsPkg.sv
// types shared by every block of the MIPS core, imported by the RTL and the testbench
package mipsPkg;

    typedef logic [31:0] wordT;   // data word or byte address
    typedef logic [4:0]  regIdxT; // register file index
    typedef logic [5:0]  opcodeT; // instr[31:26]
    typedef logic [5:0]  functT;  // instr[5:0]
    typedef logic [3:0]  aluOpT;  // values come from the ALU_* macros

    // sequencer states, HALT kept at zero
    typedef enum logic [2:0] {
        HALT   = 3'd0,
        FETCH  = 3'd1,
        DECODE = 3'd2,
        EXEC1  = 3'd3,
        EXEC2  = 3'd4
    } cpuStateT;

    // datapath strobes from the control unit
    typedef struct packed {
        aluOpT aluOp;     // operation for the ALU
        logic  aluSrcImm; // b operand from the extended immediate
        logic  zeroExt;   // zero extend the immediate instead of sign extend
        logic  jump;      // next pc from the 26 bit target
        logic  branch;    // conditional branch on the zero flag
        logic  branchNe;  // invert the zero flag for BNE
        logic  regToJump; // next pc from register A
        logic  link;      // write the return address
        logic  memRead;   // data read request
        logic  memWrite;  // data write request
        logic  regDst;    // destination is rd, otherwise rt
        logic  memToReg;  // write back load data
        logic  regWrite;  // register file write enable
        logic  irWrite;   // load the instruction register
        logic  pcToAddr;  // pc drives the bus address
        logic  pcWrite;   // commit the next pc
    } ctrlSigT;

endpackage

//--- hw/stateSequencer.sv
// state register of the multicycle core that steps fetch to exec2 and stalls on memory waitRequest
`timescale 1ns/1ps

module stateSequencer (
    input  logic              clk,
    input  logic              rstN,
    input  logic              waitRequest, // from the Avalon slave
    input  logic              memBusy,     // control is requesting the bus this cycle
    input  logic              pcIsHalt,    // next pc is the halt address
    output mipsPkg::cpuStateT state
);
    import mipsPkg::*;

    cpuStateT nextState;
    logic     stall;

    assign stall = memBusy & waitRequest; // transfer not yet accepted

    always_comb begin
        case (state)
            FETCH:   nextState = DECODE;
            DECODE:  nextState = EXEC1;
            EXEC1:   nextState = EXEC2;
            EXEC2:   nextState = pcIsHalt ? HALT : FETCH; // halt once pc lands on zero
            default: nextState = HALT;                    // HALT is terminal
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= FETCH; // first fetch straight out of reset
        end else if (!stall) begin
            state <= nextState;
        end
    end

    // once halted the core stays halted until the next reset
    haltIsFinal: assert property (
        @(posedge clk) disable iff (!rstN) state == HALT |=> state == HALT
    ) else $error("sequencer left HALT");

endmodule

//--- hw/controlUnit.sv
// combinational decoder turning opcode, funct, state and waitRequest into datapath strobes
`timescale 1ns/1ps
`include "mips_macros.svh"

module controlUnit (
    input  mipsPkg::cpuStateT state,
    input  mipsPkg::wordT     instr,
    input  logic              waitRequest,
    output mipsPkg::ctrlSigT  ctrl
);
    import mipsPkg::*;

    opcodeT opcode;
    functT  funct;
    logic   fetch, exec1, exec2;
    logic   wantRead, wantWrite, wantReg; // state independent requests from the opcode
    logic   storeStall;                   // SW still waiting for the slave

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];
    assign fetch  = state == FETCH;
    assign exec1  = state == EXEC1;
    assign exec2  = state == EXEC2;

    always_comb begin
        ctrl       = '0; // everything idle by default so HALT and DECODE need no branch
        wantRead   = 1'b0;
        wantWrite  = 1'b0;
        wantReg    = 1'b0;
        storeStall = 1'b0;
        if (fetch) begin
            ctrl.memRead  = 1'b1;         // pc onto the bus
            ctrl.pcToAddr = 1'b1;
            ctrl.irWrite  = !waitRequest; // latch on the completing cycle
        end else if (exec1 || exec2) begin
            case (opcode)
                `OP_SPECIAL: begin
                    ctrl.regDst = 1'b1; // results go to rd
                    wantReg     = 1'b1;
                    case (funct)
                        `FN_ADDU: ctrl.aluOp = `ALU_ADD;
                        `FN_SUBU: ctrl.aluOp = `ALU_SUB;
                        `FN_AND:  ctrl.aluOp = `ALU_AND;
                        `FN_OR:   ctrl.aluOp = `ALU_OR;
                        `FN_XOR:  ctrl.aluOp = `ALU_XOR;
                        `FN_SLT:  ctrl.aluOp = `ALU_SLT;
                        `FN_SLTU: ctrl.aluOp = `ALU_SLTU;
                        `FN_JR: begin
                            ctrl.regToJump = 1'b1;
                            wantReg        = 1'b0; // plain jump writes nothing
                        end
                        `FN_JALR: begin
                            ctrl.regToJump = 1'b1;
                            ctrl.link      = 1'b1; // return address into rd
                        end
                        default: wantReg = 1'b0; // unknown funct runs as a NOP
                    endcase
                end
                `OP_ADDIU: begin
                    ctrl.aluSrcImm = 1'b1;
                    wantReg        = 1'b1;
                end
                `OP_ANDI, `OP_ORI, `OP_XORI: begin
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.zeroExt   = 1'b1; // logic immediates are unsigned
                    ctrl.aluOp     = opcode == `OP_ANDI ? `ALU_AND :
                                     opcode == `OP_ORI  ? `ALU_OR  : `ALU_XOR;
                    wantReg        = 1'b1;
                end
                `OP_LUI: begin
                    ctrl.aluOp     = `ALU_LUI;
                    ctrl.aluSrcImm = 1'b1;
                    ctrl.zeroExt   = 1'b1;
                    wantReg        = 1'b1;
                end
                `OP_LW: begin
                    ctrl.aluSrcImm = 1'b1; // base plus offset
                    ctrl.memToReg  = 1'b1;
                    wantRead       = 1'b1;
                    wantReg        = 1'b1;
                end
                `OP_SW: begin
                    ctrl.aluSrcImm = 1'b1;
                    wantWrite      = 1'b1;
                end
                `OP_BEQ, `OP_BNE: begin
                    ctrl.aluOp    = `ALU_EQ; // compare rs with rt
                    ctrl.branch   = 1'b1;
                    ctrl.branchNe = opcode == `OP_BNE;
                end
                `OP_J:   ctrl.jump = 1'b1;
                `OP_JAL: begin
                    ctrl.jump = 1'b1;
                    ctrl.link = 1'b1; // return address into r31
                    wantReg   = 1'b1;
                end
                default: ; // unsupported opcode only advances the pc
            endcase
            storeStall    = wantWrite & waitRequest;
            ctrl.memRead  = wantRead & exec1;
            ctrl.memWrite = wantWrite & exec2;
            ctrl.regWrite = wantReg & exec2;
            ctrl.pcWrite  = exec2 & !storeStall; // commit when the store is accepted
        end
        assert (!(ctrl.memRead && ctrl.memWrite)) else $error("read and write requested together");
    end

endmodule

//--- hw/aluUnit.sv
// 32-bit ALU for arithmetic, logic, compares, LUI and the branch equality flag
`timescale 1ns/1ps
`include "mips_macros.svh"

module aluUnit (
    input  mipsPkg::aluOpT aluOp,
    input  mipsPkg::wordT  a,
    input  mipsPkg::wordT  b,
    output mipsPkg::wordT  result,
    output logic           zero
);
    import mipsPkg::*;

    wordT  diff;     // shared subtractor for SUB and the compares
    logic  signedLt;
    logic  unsignedLt;

    assign diff       = a - b;
    assign unsignedLt = a < b;
    // signs differ -> a negative means less, else the subtract sign decides
    assign signedLt   = (a[31] != b[31]) ? a[31] : diff[31];

    always_comb begin
        case (aluOp)
            `ALU_ADD:  result = a + b;
            `ALU_SUB:  result = diff;
            `ALU_SLT:  result = {31'b0, signedLt};
            `ALU_SLTU: result = {31'b0, unsignedLt};
            `ALU_AND:  result = a & b;
            `ALU_OR:   result = a | b;
            `ALU_XOR:  result = a ^ b;
            `ALU_LUI:  result = {b[15:0], 16'b0};
            `ALU_EQ:   result = {31'b0, a != b}; // zero result means equal
            default:   result = a + b;
        endcase
    end

    assign zero = result == '0; // branch decision input

endmodule

//--- hw/registerFile.sv
// 32 x 32-bit general register file with r0 tied to zero, two async reads and one clocked write
`timescale 1ns/1ps

module registerFile (
    input  logic            clk,
    input  logic            rstN,
    input  mipsPkg::regIdxT readIdxA,
    input  mipsPkg::regIdxT readIdxB,
    output mipsPkg::wordT   readA,
    output mipsPkg::wordT   readB,
    input  logic            writeEn,
    input  mipsPkg::regIdxT writeIdx,
    input  mipsPkg::wordT   writeData,
    output mipsPkg::wordT   regV0
);
    import mipsPkg::*;

    wordT regs [32];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != 5'd0) begin // r0 never written
            regs[writeIdx] <= writeData;
        end
    end

    assign readA = regs[readIdxA];
    assign readB = regs[readIdxB];
    assign regV0 = regs[2]; // v0 for result readout

endmodule

//--- hw/busInterface.sv
// pc, instruction and load registers plus next pc selection, drives the Avalon master
`timescale 1ns/1ps
`include "mips_macros.svh"

module busInterface (
    input  logic             clk,
    input  logic             rstN,
    input  mipsPkg::ctrlSigT ctrl,
    input  mipsPkg::wordT    aluResult,
    input  logic             aluZero,
    input  mipsPkg::wordT    regA,
    input  mipsPkg::wordT    regB,
    output mipsPkg::wordT    instr,
    output mipsPkg::wordT    loadData,
    output mipsPkg::wordT    pc,
    output mipsPkg::wordT    pcPlus4,
    output logic             pcIsHalt,
    output mipsPkg::wordT    memAddress,
    output mipsPkg::wordT    memWriteData,
    output logic             memRead,
    output logic             memWrite,
    input  mipsPkg::wordT    memReadData,
    input  logic             waitRequest
);
    import mipsPkg::*;

    wordT pcReg, irReg, loadReg;
    wordT nextPc, branchTarget, jumpTarget;
    logic branchTaken;

    assign pcPlus4      = pcReg + 32'd4;
    assign branchTarget = pcPlus4 + {{14{irReg[15]}}, irReg[15:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], irReg[25:0], 2'b00}; // stays in the 256MB region
    assign branchTaken  = ctrl.branch & (aluZero ^ ctrl.branchNe);

    always_comb begin
        if (ctrl.regToJump) nextPc = regA; // JR, JALR
        else if (ctrl.jump) nextPc = jumpTarget;
        else if (branchTaken) nextPc = branchTarget;
        else nextPc = pcPlus4;
    end

    assign pcIsHalt = nextPc == `HALT_ADDR;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) pcReg <= `RESET_VECTOR;
        else if (ctrl.pcWrite) pcReg <= nextPc;
    end

    always_ff @(posedge clk) begin
        if (ctrl.irWrite) irReg <= memReadData;
        if (ctrl.memRead && !ctrl.pcToAddr && !waitRequest) loadReg <= memReadData; // LW done
    end

    assign memAddress   = ctrl.pcToAddr ? pcReg : aluResult;
    assign memWriteData = regB; // rt for SW
    assign memRead      = ctrl.memRead;
    assign memWrite     = ctrl.memWrite;
    assign instr        = irReg;
    assign loadData     = loadReg;
    assign pc           = pcReg;

endmodule

//--- hw/mipsCpu.sv
// top level of the multicycle MIPS core, one Avalon word master for fetch and data
`timescale 1ns/1ps

module mipsCpu (
    input  logic          clk,
    input  logic          rstN,
    output mipsPkg::wordT memAddress,
    output logic          memRead,
    output logic          memWrite,
    output mipsPkg::wordT memWriteData,
    input  mipsPkg::wordT memReadData,
    input  logic          waitRequest,
    output logic          active,
    output mipsPkg::wordT regV0
);
    import mipsPkg::*;

    cpuStateT state;
    ctrlSigT  ctrl;
    wordT     instr, loadData, pc, pcPlus4;
    wordT     regA, regB, aluA, aluB, aluResult, immExt, writeData;
    regIdxT   writeIdx;
    logic     aluZero, pcIsHalt;

    stateSequencer i_seq (.clk, .rstN, .waitRequest, .memBusy(ctrl.memRead | ctrl.memWrite),
                          .pcIsHalt, .state);

    controlUnit i_ctrl (.state, .instr, .waitRequest, .ctrl);

    // operand muxes, link instructions compute pc + 4 in the ALU
    assign immExt = ctrl.zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
    assign aluA   = ctrl.link ? pc : regA;
    assign aluB   = ctrl.link ? 32'd4 : (ctrl.aluSrcImm ? immExt : regB);

    aluUnit i_alu (.aluOp(ctrl.aluOp), .a(aluA), .b(aluB), .result(aluResult), .zero(aluZero));

    // write back, JAL goes to r31 and JALR to rd
    assign writeIdx  = ctrl.regDst ? instr[15:11] : (ctrl.link ? 5'd31 : instr[20:16]);
    assign writeData = ctrl.memToReg ? loadData : aluResult;

    registerFile i_regs (.clk, .rstN, .readIdxA(instr[25:21]), .readIdxB(instr[20:16]),
                         .readA(regA), .readB(regB), .writeEn(ctrl.regWrite), .writeIdx,
                         .writeData, .regV0);

    busInterface i_bus (.clk, .rstN, .ctrl, .aluResult, .aluZero, .regA, .regB, .instr,
                        .loadData, .pc, .pcPlus4, .pcIsHalt, .memAddress, .memWriteData,
                        .memRead, .memWrite, .memReadData, .waitRequest);

    assign active = state != HALT;

    // return address from the ALU agrees with the sequential pc of the bus block
    linkIsPcPlus4: assert property (
        @(posedge clk) disable iff (!rstN) ctrl.regWrite && ctrl.link |-> writeData == pcPlus4
    ) else $error("link value differs from pc + 4");

    // halted core keeps the bus quiet
    quietWhenHalted: assert property (
        @(posedge clk) disable iff (!rstN) !active |-> !memRead && !memWrite
    ) else $error("bus request after halt");

endmodule

//--- verification/avalonMemory.sv
// sparse word memory for the testbench, Avalon slave with random waitRequest and a log of writes
`timescale 1ns/1ps

module avalonMemory (
    input  logic          clk,
    input  logic          rstN,
    input  mipsPkg::wordT address,
    input  logic          read,
    input  logic          write,
    input  mipsPkg::wordT writeData,
    output mipsPkg::wordT readData,
    output logic          waitRequest
);
    import mipsPkg::*;

    wordT       mem [wordT];      // contents keyed by byte address, preloaded by the testbench
    wordT       writeAddrLog [$]; // every accepted write, in bus order
    wordT       writeDataLog [$];
    logic [1:0] stallTarget;      // wait cycles for the current transfer
    logic [1:0] stallCount;       // wait cycles spent so far
    logic       request;

    assign request     = read | write;
    assign waitRequest = request && stallCount != stallTarget;

    always_comb begin
        if (mem.exists(address)) readData = mem[address];
        else readData = {~address[15:0], address[31:16]}; // untouched words, whole address
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            stallCount  <= '0;
            stallTarget <= 2'd1;
        end else if (request && waitRequest) begin
            stallCount <= stallCount + 2'd1;
        end else if (request) begin
            stallCount  <= '0; // transfer done, draw the next stall length
            stallTarget <= 2'($urandom_range(3, 0));
        end
    end

    // write port, committed on the accepting edge
    always @(posedge clk) begin
        if (rstN && write && !waitRequest) begin
            mem[address] = writeData;
            writeAddrLog.push_back(address);
            writeDataLog.push_back(writeData);
        end
    end

endmodule

//--- verification/mipsCpuTb.sv
// testbench for mipsCpu, runs a random program against an instruction set model under bus stalls
`timescale 1ns/1ps
`include "mips_macros.svh"

module mipsCpuTb;
    import mipsPkg::*;

    localparam int   ITEMS     = 60;           // random program items before the final JR
    localparam wordT DATA_BASE = 32'h10000100; // start of the 64 word data region
    localparam int   CLK_NS    = 4;

    logic   clk, rstN;
    wordT   memAddress, memWriteData, memReadData, regV0;
    logic   memRead, memWrite, waitRequest, active;
    wordT   image [wordT];   // program and data, later the model's memory
    wordT   expReads [$];    // fetch and load addresses from the model
    wordT   expWriteAddr [$];
    wordT   expWriteData [$];
    wordT   modelRegs [32];
    wordT   progEnd;
    int     instrCount;
    longint limitNs;
    logic   readSeen;        // first fetch completed

    mipsCpu i_dut (.clk, .rstN, .memAddress, .memRead, .memWrite, .memWriteData, .memReadData,
                   .waitRequest, .active, .regV0);

    avalonMemory i_mem (.clk, .rstN, .address(memAddress), .read(memRead), .write(memWrite),
                        .writeData(memWriteData), .readData(memReadData), .waitRequest);

    function automatic wordT rFormat(functT fn, regIdxT rs, regIdxT rt, regIdxT rd);
        return {`OP_SPECIAL, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic wordT iFormat(opcodeT op, regIdxT rs, regIdxT rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jFormat(opcodeT op, wordT target);
        return {op, target[27:2]};
    endfunction

    function automatic regIdxT anyReg(); // r28 base and r31 link stay out
        return regIdxT'($urandom_range(27, 0));
    endfunction

    function automatic regIdxT destReg();
        return regIdxT'($urandom_range(27, 1));
    endfunction

    task automatic stopWithFailure(string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic placeWord(wordT instr);
        image[progEnd] = instr;
        progEnd += 32'd4;
    endtask

    task automatic randomAluOp();
        functT  fns [7] = '{`FN_ADDU, `FN_SUBU, `FN_AND, `FN_OR, `FN_XOR, `FN_SLT, `FN_SLTU};
        opcodeT ops [5] = '{`OP_ADDIU, `OP_ANDI, `OP_ORI, `OP_XORI, `OP_LUI};
        if ($urandom_range(1, 0) != 0)
            placeWord(rFormat(fns[$urandom_range(6, 0)], anyReg(), anyReg(), destReg()));
        else
            placeWord(iFormat(ops[$urandom_range(4, 0)], anyReg(), destReg(), 16'($urandom)));
    endtask

    task automatic buildProgram();
        int     kind, skip;
        wordT   here;
        regIdxT rs, rt;
        progEnd = `RESET_VECTOR;
        placeWord(iFormat(`OP_LUI, 5'd0, 5'd28, DATA_BASE[31:16])); // data base into r28
        placeWord(iFormat(`OP_ORI, 5'd28, 5'd28, DATA_BASE[15:0]));
        for (int i = 0; i < 64; i++) begin
            image[DATA_BASE + wordT'(4 * i)] = $urandom;
        end
        for (int n = 0; n < ITEMS; n++) begin
            kind = $urandom_range(9, 0);
            skip = $urandom_range(3, 1);
            here = progEnd;
            rs   = anyReg();
            rt   = ($urandom_range(1, 0) != 0) ? rs : anyReg(); // equal operands half the time
            case (kind)
                4: placeWord(iFormat(`OP_LW, 5'd28, destReg(), 16'(4 * $urandom_range(63, 0))));
                5: placeWord(iFormat(`OP_SW, 5'd28, anyReg(), 16'(4 * $urandom_range(63, 0))));
                6, 7: begin // forward branch over skip ops
                    placeWord(iFormat(kind == 6 ? `OP_BEQ : `OP_BNE, rs, rt, 16'(skip)));
                    repeat (skip) randomAluOp();
                end
                8: begin
                    placeWord(jFormat(`OP_J, here + wordT'(4 * (skip + 1))));
                    repeat (skip) randomAluOp();
                end
                9: begin // call a short routine, return lands on a J past it
                    placeWord(jFormat(`OP_JAL, here + 32'd8));
                    placeWord(jFormat(`OP_J, here + 32'd16));
                    randomAluOp();
                    if ($urandom_range(1, 0) != 0) placeWord(rFormat(`FN_JR, 5'd31, 5'd0, 5'd0));
                    else placeWord(rFormat(`FN_JALR, 5'd31, 5'd0, destReg()));
                end
                default: randomAluOp();
            endcase
        end
        placeWord(rFormat(`FN_JR, 5'd0, 5'd0, 5'd0)); // jump to zero halts
    endtask

    task automatic setModelReg(regIdxT idx, wordT value);
        if (idx != 5'd0) modelRegs[idx] = value;
    endtask

    // reference interpreter, no delay slots, records every bus transfer it expects
    task automatic runModel();
        wordT   pc, instr, a, b, sext, zext, next, addr;
        regIdxT rs, rt, rd;
        pc = `RESET_VECTOR;
        foreach (modelRegs[i]) modelRegs[i] = '0;
        while (pc != `HALT_ADDR) begin
            if (instrCount > 10000) stopWithFailure("model did not reach the halt address");
            expReads.push_back(pc);
            instr = image[pc];
            rs    = instr[25:21];
            rt    = instr[20:16];
            rd    = instr[15:11];
            a     = modelRegs[rs];
            b     = modelRegs[rt];
            sext  = {{16{instr[15]}}, instr[15:0]};
            zext  = {16'b0, instr[15:0]};
            next  = pc + 32'd4;
            addr  = a + sext;
            instrCount++;
            case (instr[31:26])
                `OP_SPECIAL: begin
                    case (instr[5:0])
                        `FN_ADDU: setModelReg(rd, a + b);
                        `FN_SUBU: setModelReg(rd, a - b);
                        `FN_AND:  setModelReg(rd, a & b);
                        `FN_OR:   setModelReg(rd, a | b);
                        `FN_XOR:  setModelReg(rd, a ^ b);
                        `FN_SLT:  setModelReg(rd, {31'b0, $signed(a) < $signed(b)});
                        `FN_SLTU: setModelReg(rd, {31'b0, a < b});
                        `FN_JR:   next = a;
                        `FN_JALR: begin
                            setModelReg(rd, pc + 32'd4);
                            next = a; // rs read before the link write
                        end
                        default: ;
                    endcase
                end
                `OP_ADDIU: setModelReg(rt, a + sext);
                `OP_ANDI:  setModelReg(rt, a & zext);
                `OP_ORI:   setModelReg(rt, a | zext);
                `OP_XORI:  setModelReg(rt, a ^ zext);
                `OP_LUI:   setModelReg(rt, {instr[15:0], 16'b0});
                `OP_LW: begin
                    expReads.push_back(addr);
                    setModelReg(rt, image[addr]);
                end
                `OP_SW: begin
                    expWriteAddr.push_back(addr);
                    expWriteData.push_back(b);
                    image[addr] = b;
                end
                `OP_BEQ: if (a == b) next = next + {sext[29:0], 2'b00};
                `OP_BNE: if (a != b) next = next + {sext[29:0], 2'b00};
                `OP_J:   next = {next[31:28], instr[25:0], 2'b00};
                `OP_JAL: begin
                    setModelReg(5'd31, pc + 32'd4);
                    next = {next[31:28], instr[25:0], 2'b00};
                end
                default: ;
            endcase
            pc = next;
        end
    endtask

    task automatic checkRead(wordT address);
        wordT expected;
        if (expReads.size() == 0) begin
            stopWithFailure("core read past the last transfer of the model");
        end else begin
            expected = expReads.pop_front();
            if (address !== expected)
                stopWithFailure($sformatf("MISMATCH memAddress got %h expected %h",
                                          address, expected));
        end
    endtask

    task automatic checkWrite(wordT address, wordT data);
        wordT expAddr, expData;
        if (expWriteAddr.size() == 0) begin
            stopWithFailure("core stored more words than the model");
        end else begin
            expAddr = expWriteAddr.pop_front();
            expData = expWriteData.pop_front();
            if (address !== expAddr)
                stopWithFailure($sformatf("MISMATCH memAddress got %h expected %h",
                                          address, expAddr));
            else if (data !== expData)
                stopWithFailure($sformatf("MISMATCH memWriteData got %h expected %h",
                                          data, expData));
        end
    endtask

    task automatic checkReg(wordT v0);
        if (v0 !== modelRegs[2])
            stopWithFailure($sformatf("MISMATCH regV0 got %h expected %h", v0, modelRegs[2]));
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // bus monitor, outputs are settled at the falling edge
    always @(negedge clk) begin
        if (rstN) begin
            if (!active && (memRead || memWrite)) begin
                stopWithFailure("bus request after the core halted");
            end else if (memWrite && !readSeen) begin
                stopWithFailure("write issued before the first fetch completed");
            end else if (memRead && !waitRequest) begin
                checkRead(memAddress);
                readSeen = 1'b1;
            end
        end
    end

    initial begin
        wait (limitNs != 0);
        #(limitNs);
        stopWithFailure("timeout, the core did not halt in time");
    end

    initial begin
        void'($urandom(32'h4f7b6152));
        rstN       = 1'b0;
        readSeen   = 1'b0;
        limitNs    = 0;
        instrCount = 0;
        buildProgram();
        foreach (image[addr]) i_mem.mem[addr] = image[addr];
        runModel(); // changes image from here on, the memory keeps its copy
        limitNs = longint'(instrCount) * 20 * CLK_NS;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        while (active) @(negedge clk);
        repeat (8) @(negedge clk); // bus has to stay idle after halt
        checkReg(regV0);
        for (int i = 0; i < i_mem.writeAddrLog.size(); i++) begin
            checkWrite(i_mem.writeAddrLog[i], i_mem.writeDataLog[i]);
        end
        if (expReads.size() != 0) begin
            stopWithFailure("core halted before the last transfer of the model");
        end else if (expWriteAddr.size() != 0) begin
            stopWithFailure("core stored fewer words than the model");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

//--- src.f
+incdir+hw
hw/mipsPkg.sv
hw/stateSequencer.sv
hw/controlUnit.sv
hw/aluUnit.sv
hw/registerFile.sv
hw/busInterface.sv
hw/mipsCpu.sv
verification/avalonMemory.sv
verification/mipsCpuTb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ps -f src.f --top-module mipsCpuTb \
    || { echo "build failed"; exit 1; }
out=$(./obj_dir/VmipsCpuTb 2>&1)
echo "$out"
echo "$out" | grep -qx "Simulation finished: PASS" && echo "run passed" \
    || { echo "run failed"; exit 1; }
